/* build.f */
common/exPkg.sv
common/aluFlagsIf.sv
design/alu.sv
design/branchUnit.sv
multiply/multUnit.sv
design/exControl.sv
design/executeFront.sv
design/executeAcc.sv
design/executeStage.sv
sim/tbExecute.sv

/* common/aluFlagsIf.sv */
//----------------------------------------------------------
// Status flags of one execute unit
//----------------------------------------------------------
`timescale 1ns/1ns

interface aluFlagsIf;

    logic c;
    logic z;
    logic o;
    logic n;

    modport source (output c, z, o, n);     // Producing unit
    modport sink   (input  c, z, o, n);     // Branch check and control

endinterface

/* common/exPkg.sv */
//----------------------------------------------------------
// Execute stage package
// Widths, operation enums and the flag struct
//----------------------------------------------------------
package exPkg;

    localparam int dataW = 32;              // Datapath width
    localparam int accW  = 64;              // Product and accumulator width

    // ALU operations use the MIPS function field
    typedef enum logic [5:0] {
        SLL  = 6'h00,
        SRL  = 6'h02,
        SRA  = 6'h03,
        ADD  = 6'h20,
        ADDU = 6'h21,
        SUB  = 6'h22,
        SUBU = 6'h23,
        AND  = 6'h24,
        OR   = 6'h25,
        XOR  = 6'h26,
        NOR  = 6'h27,
        SLT  = 6'h2a,
        SLTU = 6'h2b
    } aluFuncE;

    typedef enum logic [5:0] {
        MADD  = 6'h00,                      // SPECIAL2 group
        MADDU = 6'h01,
        MULT  = 6'h18,
        MULTU = 6'h19
    } mulFuncE;

    // Three low opcode bits of branches and jumps
    typedef enum logic [2:0] {
        BCOND = 3'b001,                     // BLTZ or BGEZ by rt
        J     = 3'b010,
        JAL   = 3'b011,
        BEQ   = 3'b100,
        BNE   = 3'b101,
        BLEZ  = 3'b110,
        BGTZ  = 3'b111
    } brCodeE;

    typedef enum logic [1:0] {
        SEL_ALU = 2'b00,
        SEL_BRA = 2'b01,
        SEL_MUL = 2'b10
    } outSelE;

    typedef struct packed {
        logic c;                            // Carry
        logic z;                            // Zero
        logic o;                            // Signed overflow
        logic n;                            // Negative
    } flagsT;

endpackage

/* design/alu.sv */
//----------------------------------------------------------
// 32-bit ALU
// Arithmetic, logic, compare and shifts with status flags
//----------------------------------------------------------
`timescale 1ns/1ns

module alu (
    input  logic [exPkg::dataW-1:0] a,
    input  logic [exPkg::dataW-1:0] b,
    input  logic [4:0]              shamt,
    input  exPkg::aluFuncE          aluFunc,
    input  logic                    en,
    output logic [exPkg::dataW-1:0] result,
    aluFlagsIf.source               flags
);

    logic [exPkg::dataW:0]   wide;          // Sum or difference with carry
    logic [exPkg::dataW-1:0] res;
    logic                    addSub;
    logic                    ovf;
    logic                    illegal;

    always_comb begin
        wide    = '0;
        res     = '0;
        addSub  = 1'b0;
        illegal = 1'b0;
        case (aluFunc)
            exPkg::ADD, exPkg::ADDU: begin
                wide   = {1'b0, a} + {1'b0, b};
                res    = wide[exPkg::dataW-1:0];
                addSub = 1'b1;
            end
            exPkg::SUB, exPkg::SUBU: begin
                wide   = {1'b0, a} - {1'b0, b}; // Carry holds the borrow
                res    = wide[exPkg::dataW-1:0];
                addSub = 1'b1;
            end
            exPkg::AND:  res = a & b;
            exPkg::OR:   res = a | b;
            exPkg::XOR:  res = a ^ b;
            exPkg::NOR:  res = ~(a | b);
            exPkg::SLT:  res = {{(exPkg::dataW-1){1'b0}}, $signed(a) < $signed(b)};
            exPkg::SLTU: res = {{(exPkg::dataW-1){1'b0}}, a < b};
            exPkg::SLL:  res = b << shamt;
            exPkg::SRL:  res = b >> shamt;
            exPkg::SRA:  res = $signed(b) >>> shamt; // Sign fill
            default:     illegal = 1'b1;
        endcase
    end

    // Overflow only for the signed add and subtract
    always_comb begin
        case (aluFunc)
            exPkg::ADD: ovf = (a[exPkg::dataW-1] == b[exPkg::dataW-1]) &&
                              (res[exPkg::dataW-1] != a[exPkg::dataW-1]);
            exPkg::SUB: ovf = (a[exPkg::dataW-1] != b[exPkg::dataW-1]) &&
                              (res[exPkg::dataW-1] != a[exPkg::dataW-1]);
            default:    ovf = 1'b0;
        endcase
    end

    assign result  = en ? res : '0;
    assign flags.c = en & addSub & wide[exPkg::dataW];
    assign flags.o = en & ovf;
    assign flags.z = (result == '0);
    assign flags.n = result[exPkg::dataW-1];

    always_comb begin
        if (en) begin
            assert final (!illegal)
                else $error("alu: function code %0h is not an ALU operation", aluFunc);
        end
    end

endmodule

/* design/branchUnit.sv */
//----------------------------------------------------------
// Branch unit
// Condition check on ALU flags, target and return address
//----------------------------------------------------------
`timescale 1ns/1ns

module branchUnit (
    input  logic                    enable,
    aluFlagsIf.sink                 flags,
    input  logic [exPkg::dataW-1:0] pcIn,
    input  logic [exPkg::dataW-1:0] address,    // Jump target operand
    input  logic [exPkg::dataW-1:0] imm,
    input  exPkg::brCodeE           brCode,
    input  logic                    brRt,       // Low rt bit picks BGEZ
    output logic [exPkg::dataW-1:0] pcOut,
    output logic [exPkg::dataW-1:0] ret,
    output logic                    taken
);

    logic                    cond;
    logic                    isJump;
    logic [exPkg::dataW-1:0] target;

    always_comb begin
        case (brCode)
            exPkg::BCOND:        cond = brRt ? !flags.n : flags.n;
            exPkg::J, exPkg::JAL: cond = 1'b1;
            exPkg::BEQ:          cond = flags.z;
            exPkg::BNE:          cond = !flags.z;
            exPkg::BLEZ:         cond = flags.n | flags.z;
            exPkg::BGTZ:         cond = !(flags.n | flags.z);
            default:             cond = 1'b0;
        endcase
    end

    assign isJump = (brCode == exPkg::J) || (brCode == exPkg::JAL);
    assign target = isJump ? address : pcIn + {imm[exPkg::dataW-3:0], 2'b00};
    assign taken  = enable & cond;
    assign pcOut  = taken ? target : pcIn;
    assign ret    = (brCode == exPkg::JAL) ? pcIn + 32'd4 : '0; // Link address

endmodule

/* design/exControl.sv */
//----------------------------------------------------------
// Execute control
// Unit enables, result select and write-back qualifiers
//----------------------------------------------------------
`timescale 1ns/1ns

module exControl (
    input  logic           aluOp,
    input  logic           mulOp,
    input  logic           jump,
    input  logic           branch,
    input  logic           regWriteIn,
    input  logic           memWriteIn,
    input  logic           braTaken,
    input  exPkg::aluFuncE aluFunc,
    input  exPkg::mulFuncE mulFunc,
    aluFlagsIf.sink        flags,
    output logic           aluEn,
    output logic           braEn,
    output logic           accEn,
    output logic           regWriteOut,
    output logic           memWriteOut,
    output logic           branchTaken,
    output exPkg::outSelE  outSel
);

    logic anyOp;
    logic isMac;
    logic ovfTrap;

    assign anyOp = aluOp | mulOp | jump | branch;   // Low on a bubble
    assign isMac = mulOp &&
                   (mulFunc == exPkg::MADD || mulFunc == exPkg::MADDU);

    // Trapping add and subtract never write a wrapped value
    assign ovfTrap = aluOp && flags.o &&
                     (aluFunc == exPkg::ADD || aluFunc == exPkg::SUB);

    assign aluEn = aluOp | branch;                  // Branches compare with SUB
    assign braEn = jump | branch;
    assign accEn = isMac;

    assign outSel = mulOp           ? exPkg::SEL_MUL :
                    (jump | branch) ? exPkg::SEL_BRA : exPkg::SEL_ALU;

    // Jumps write only when decode marks a link
    assign regWriteOut = regWriteIn & anyOp & !isMac & !branch & !ovfTrap;
    assign memWriteOut = memWriteIn & aluOp;
    assign branchTaken = braTaken & braEn;

    always_comb begin
        assert final ($onehot0({aluOp, mulOp, jump, branch}))
            else $error("exControl: more than one op strobe is high");
    end

endmodule

/* design/executeAcc.sv */
//----------------------------------------------------------
// Execute pipeline register
// Latches front stage results and holds the MAC accumulator
//----------------------------------------------------------
`timescale 1ns/1ns

module executeAcc (
    input  logic                    clk,
    input  logic                    arstN,
    input  logic [exPkg::accW-1:0]  frontResult,
    input  exPkg::flagsT            frontFlags,
    input  logic [exPkg::dataW-1:0] frontPcOut,
    input  logic                    frontRegWrite,
    input  logic                    frontMemWrite,
    input  logic                    frontBranchTaken,
    input  logic                    accEn,
    output logic [exPkg::accW-1:0]  out,
    output exPkg::flagsT            flags,
    output logic [exPkg::dataW-1:0] pcOut,
    output logic                    regWriteOut,
    output logic                    memWriteOut,
    output logic                    branchTaken,
    output logic [exPkg::accW-1:0]  accState
);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            out         <= '0;
            flags       <= '0;
            pcOut       <= '0;
            regWriteOut <= 1'b0;
            memWriteOut <= 1'b0;
            branchTaken <= 1'b0;
            accState    <= '0;
        end else begin
            out         <= frontResult;
            flags       <= frontFlags;
            pcOut       <= frontPcOut;
            regWriteOut <= frontRegWrite;
            memWriteOut <= frontMemWrite;
            branchTaken <= frontBranchTaken;
            if (accEn) begin
                accState <= frontResult;        // Sum from MADD or MADDU
            end
        end
    end

    // A store never redirects the PC in the same slot
    assert property (@(posedge clk) disable iff (!arstN) !(branchTaken && memWriteOut))
        else $error("executeAcc: branch and store qualifiers high together");

endmodule

/* design/executeFront.sv */
//----------------------------------------------------------
// First execute stage
// Operand select, ALU, branch and multiply, result select
//----------------------------------------------------------
`timescale 1ns/1ns

module executeFront (
    input  logic                    aluOp,
    input  logic                    mulOp,
    input  logic                    jump,
    input  logic                    branch,
    input  logic                    zeroB,      // Compare against zero
    input  logic                    regWriteIn,
    input  logic                    memWriteIn,
    input  logic                    aluSrc,     // Immediate as operand B
    input  logic                    braSrc,     // Immediate as jump target
    input  logic [exPkg::dataW-1:0] a,
    input  logic [exPkg::dataW-1:0] b,
    input  logic [exPkg::dataW-1:0] imm,
    input  logic [exPkg::dataW-1:0] pcIn,
    input  logic [4:0]              shamt,
    input  exPkg::aluFuncE          aluFunc,
    input  exPkg::mulFuncE          mulFunc,
    input  exPkg::brCodeE           brCode,
    input  logic                    brRt,
    input  logic [exPkg::accW-1:0]  accIn,
    output logic [exPkg::accW-1:0]  result,
    output exPkg::flagsT            flags,
    output logic [exPkg::dataW-1:0] pcOut,
    output logic                    regWriteOut,
    output logic                    memWriteOut,
    output logic                    branchTaken,
    output logic                    accEn
);

    logic [exPkg::dataW-1:0] opB;
    logic [exPkg::dataW-1:0] braAddr;
    logic [exPkg::dataW-1:0] aluRes;
    logic [exPkg::dataW-1:0] braRet;
    logic [exPkg::accW-1:0]  mulProd;
    logic                    aluEn;
    logic                    braEn;
    logic                    braTaken;
    exPkg::outSelE           outSel;

    aluFlagsIf aluFlags ();
    aluFlagsIf mulFlags ();

    assign opB     = zeroB ? '0 : aluSrc ? imm : b;
    assign braAddr = braSrc ? imm : a;

    //------------------------------------------------------
    // Execute units
    //------------------------------------------------------
    alu u_alu (
        .a       (a),
        .b       (opB),
        .shamt   (shamt),
        .aluFunc (aluFunc),
        .en      (aluEn),
        .result  (aluRes),
        .flags   (aluFlags.source)
    );

    branchUnit u_branch (
        .enable  (braEn),
        .flags   (aluFlags.sink),
        .pcIn    (pcIn),
        .address (braAddr),
        .imm     (imm),
        .brCode  (brCode),
        .brRt    (brRt),
        .pcOut   (pcOut),
        .ret     (braRet),
        .taken   (braTaken)
    );

    multUnit u_mult (
        .a       (a),
        .b       (opB),
        .mulFunc (mulFunc),
        .accIn   (accIn),
        .product (mulProd),
        .flags   (mulFlags.source)
    );

    exControl u_control (
        .aluOp       (aluOp),
        .mulOp       (mulOp),
        .jump        (jump),
        .branch      (branch),
        .regWriteIn  (regWriteIn),
        .memWriteIn  (memWriteIn),
        .braTaken    (braTaken),
        .aluFunc     (aluFunc),
        .mulFunc     (mulFunc),
        .flags       (aluFlags.sink),
        .aluEn       (aluEn),
        .braEn       (braEn),
        .accEn       (accEn),
        .regWriteOut (regWriteOut),
        .memWriteOut (memWriteOut),
        .branchTaken (branchTaken),
        .outSel      (outSel)
    );

    //------------------------------------------------------
    // Result and flag select
    //------------------------------------------------------
    always_comb begin
        case (outSel)
            exPkg::SEL_MUL: begin
                result = mulProd;
                flags  = {mulFlags.c, mulFlags.z, mulFlags.o, mulFlags.n};
            end
            exPkg::SEL_BRA: begin
                result = {{(exPkg::accW-exPkg::dataW){1'b0}}, braRet};
                flags  = '0;                    // Branches report no flags
            end
            default: begin
                result = {{(exPkg::accW-exPkg::dataW){1'b0}}, aluRes};
                flags  = {aluFlags.c, aluFlags.z, aluFlags.o, aluFlags.n};
            end
        endcase
    end

endmodule

/* design/executeStage.sv */
//----------------------------------------------------------
// Execute stage top
// Combinational front end followed by the pipeline register
//----------------------------------------------------------
`timescale 1ns/1ns

module executeStage (
    input  logic                    clk,
    input  logic                    arstN,
    input  logic                    aluOp,
    input  logic                    mulOp,
    input  logic                    jump,
    input  logic                    branch,
    input  logic                    zeroB,
    input  logic                    regWriteIn,
    input  logic                    memWriteIn,
    input  logic                    aluSrc,
    input  logic                    braSrc,
    input  logic [exPkg::dataW-1:0] a,
    input  logic [exPkg::dataW-1:0] b,
    input  logic [exPkg::dataW-1:0] imm,
    input  logic [exPkg::dataW-1:0] pcIn,
    input  logic [4:0]              shamt,
    input  exPkg::aluFuncE          aluFunc,
    input  exPkg::mulFuncE          mulFunc,
    input  exPkg::brCodeE           brCode,
    input  logic                    brRt,
    output logic [exPkg::accW-1:0]  out,
    output exPkg::flagsT            flags,
    output logic [exPkg::dataW-1:0] pcOut,
    output logic                    regWriteOut,
    output logic                    memWriteOut,
    output logic                    branchTaken
);

    logic [exPkg::accW-1:0]  frontResult;
    exPkg::flagsT            frontFlags;
    logic [exPkg::dataW-1:0] frontPcOut;
    logic                    frontRegWrite;
    logic                    frontMemWrite;
    logic                    frontBranchTaken;
    logic                    accEn;
    logic [exPkg::accW-1:0]  accState;     // Fed back for accumulate

    executeFront u_front (
        .aluOp       (aluOp),
        .mulOp       (mulOp),
        .jump        (jump),
        .branch      (branch),
        .zeroB       (zeroB),
        .regWriteIn  (regWriteIn),
        .memWriteIn  (memWriteIn),
        .aluSrc      (aluSrc),
        .braSrc      (braSrc),
        .a           (a),
        .b           (b),
        .imm         (imm),
        .pcIn        (pcIn),
        .shamt       (shamt),
        .aluFunc     (aluFunc),
        .mulFunc     (mulFunc),
        .brCode      (brCode),
        .brRt        (brRt),
        .accIn       (accState),
        .result      (frontResult),
        .flags       (frontFlags),
        .pcOut       (frontPcOut),
        .regWriteOut (frontRegWrite),
        .memWriteOut (frontMemWrite),
        .branchTaken (frontBranchTaken),
        .accEn       (accEn)
    );

    executeAcc u_acc (
        .clk              (clk),
        .arstN            (arstN),
        .frontResult      (frontResult),
        .frontFlags       (frontFlags),
        .frontPcOut       (frontPcOut),
        .frontRegWrite    (frontRegWrite),
        .frontMemWrite    (frontMemWrite),
        .frontBranchTaken (frontBranchTaken),
        .accEn            (accEn),
        .out              (out),
        .flags            (flags),
        .pcOut            (pcOut),
        .regWriteOut      (regWriteOut),
        .memWriteOut      (memWriteOut),
        .branchTaken      (branchTaken),
        .accState         (accState)
    );

endmodule

/* multiply/multUnit.sv */
//----------------------------------------------------------
// 32x32 multiplier
// Signed or unsigned product with optional accumulate
//----------------------------------------------------------
`timescale 1ns/1ns

module multUnit (
    input  logic [exPkg::dataW-1:0] a,
    input  logic [exPkg::dataW-1:0] b,
    input  exPkg::mulFuncE          mulFunc,
    input  logic [exPkg::accW-1:0]  accIn,
    output logic [exPkg::accW-1:0]  product,
    aluFlagsIf.source               flags
);

    logic [exPkg::accW-1:0] prodS;
    logic [exPkg::accW-1:0] prodU;

    assign prodS = $signed(a) * $signed(b); // Sign extended to 64 bits
    assign prodU = a * b;

    always_comb begin
        case (mulFunc)
            exPkg::MULT:  product = prodS;
            exPkg::MULTU: product = prodU;
            exPkg::MADD:  product = accIn + prodS;
            exPkg::MADDU: product = accIn + prodU;
            default:      product = '0;
        endcase
    end

    assign flags.c = 1'b0;
    assign flags.o = 1'b0;
    assign flags.z = (product == '0);
    assign flags.n = product[exPkg::accW-1];

endmodule

/* sim/exInput.txt */
# name gap ctrl(aluOp mulOp jump branch zeroB regWr memWr aluSrc braSrc) a b imm pcIn shamt
# aluFunc mulFunc brCode brRt, then expected out, flags(c z o n), pcOut, regWriteOut, taken
addReg 0 100001000 00000005 00000003 00000000 00400000 00 20 18 4 0 0000000000000008 0000 00400000 1 0
addImm 0 100001010 00000010 ffffffff fffffff0 00400004 00 20 18 4 0 0000000000000000 1100 00400004 1 0
addOvf 0 100001000 7fffffff 00000001 00000000 00400008 00 20 18 4 0 0000000080000000 0011 00400008 0 0
adduWrap 0 100001000 ffffffff 00000002 00000000 0040000c 00 21 18 4 0 0000000000000001 1000 0040000c 1 0
subNeg 0 100001000 00000003 00000005 00000000 00400010 00 22 18 4 0 00000000fffffffe 1001 00400010 1 0
andImm 0 100001010 f0f0f0f0 00000000 0000ffff 00400014 00 24 18 4 0 000000000000f0f0 0000 00400014 1 0
norReg 0 100001000 00000000 00000000 00000000 00400018 00 27 18 4 0 00000000ffffffff 0001 00400018 1 0
sltNeg 0 100001000 ffffffff 00000001 00000000 0040001c 00 2a 18 4 0 0000000000000001 0000 0040001c 1 0
sltuBig 0 100001000 ffffffff 00000001 00000000 00400020 00 2b 18 4 0 0000000000000000 0100 00400020 1 0
sllFour 0 100001000 00000000 00000003 00000000 00400024 04 00 18 4 0 0000000000000030 0000 00400024 1 0
sraFill 0 100001000 00000000 80000000 00000000 00400028 04 03 18 4 0 00000000f8000000 0001 00400028 1 0
srlZero 0 100001000 00000000 80000000 00000000 0040002c 04 02 18 4 0 0000000008000000 0000 0040002c 1 0
xorImm 0 100001010 12345678 00000000 ffffffff 00400030 00 26 18 4 0 00000000edcba987 0001 00400030 1 0
beqTaken 1 000100000 00000007 00000007 00000010 00400100 00 22 18 4 0 0000000000000000 0000 00400140 0 1
beqNot 0 000100000 00000007 00000008 00000010 00400104 00 22 18 4 0 0000000000000000 0000 00400104 0 0
bneTaken 0 000101000 00000001 00000002 fffffffc 00400108 00 22 18 5 0 0000000000000000 0000 004000f8 0 1
blezTaken 0 000110000 00000000 12345678 00000008 0040010c 00 22 18 6 0 0000000000000000 0000 0040012c 0 1
blezNeg 0 000110000 fffffff0 00000000 00000004 00400110 00 22 18 6 0 0000000000000000 0000 00400120 0 1
bgtzNot 0 000110000 00000000 00000000 00000004 00400114 00 22 18 7 0 0000000000000000 0000 00400114 0 0
bgtzTaken 0 000110000 00000005 00000000 00000004 00400118 00 22 18 7 0 0000000000000000 0000 00400128 0 1
bltzTaken 0 000110000 80000000 00000000 00000002 0040011c 00 22 18 1 0 0000000000000000 0000 00400124 0 1
bltzNot 0 000110000 00000003 00000000 00000002 00400120 00 22 18 1 0 0000000000000000 0000 00400120 0 0
bgezNot 0 000110000 fffffffe 00000000 00000001 00400124 00 22 18 1 1 0000000000000000 0000 00400124 0 0
bgezTaken 0 000110000 00000000 00000000 00000001 00400128 00 22 18 1 1 0000000000000000 0000 0040012c 0 1
jImm 1 001000001 00000000 00000000 00401000 00400200 00 22 18 2 0 0000000000000000 0000 00401000 0 1
jReg 0 001000000 00402000 00000000 00000000 00400204 00 22 18 2 0 0000000000000000 0000 00402000 0 1
jalReg 0 001001000 00403000 00000000 00000000 00400208 00 22 18 3 0 000000000040020c 0000 00403000 1 1
jalImm 0 001001001 00000000 00000000 00404000 0040020c 00 22 18 3 0 0000000000400210 0000 00404000 1 1
multNeg 1 010001000 fffffffe 00000003 00000000 00400300 00 20 18 4 0 fffffffffffffffa 0001 00400300 1 0
multuBig 0 010001000 ffffffff ffffffff 00000000 00400304 00 20 19 4 0 fffffffe00000001 0001 00400304 1 0
multZero 0 010001000 12345678 00000000 00000000 00400308 00 20 18 4 0 0000000000000000 0100 00400308 1 0
madd1 2 010001000 00000064 00000003 00000000 0040030c 00 20 00 4 0 000000000000012c 0000 0040030c 0 0
madd2 0 010001000 fffffff6 00000005 00000000 00400310 00 20 00 4 0 00000000000000fa 0000 00400310 0 0
madd3 3 010001000 ffffff9c 00000004 00000000 00400314 00 20 00 4 0 ffffffffffffff6a 0001 00400314 0 0
maddu4 1 010001000 80000000 00000002 00000000 00400318 00 20 01 4 0 00000000ffffff6a 0000 00400318 0 0
madd5 0 010001000 00000096 00000001 00000000 0040031c 00 20 00 4 0 0000000100000000 0000 0040031c 0 0
multKeep 0 010001000 00000003 00000003 00000000 00400320 00 20 18 4 0 0000000000000009 0000 00400320 1 0
maddKeep 0 010001000 00000001 00000001 00000000 00400324 00 20 00 4 0 0000000100000001 0000 00400324 0 0
addBack 0 100001000 00000001 00000001 00000000 00400328 00 21 18 4 0 0000000000000002 0000 00400328 1 0

/* sim/tbExecute.sv */
//----------------------------------------------------------
// Execute stage testbench
// Replays vectors from the data file with random bubbles
// in between and checks each result one cycle later
//----------------------------------------------------------
`timescale 1ns/1ns

module tbExecute;

    localparam int maxVec = 64;

    logic                    clk;
    logic                    arstN;
    logic                    aluOp, mulOp, jump, branch, zeroB;
    logic                    regWriteIn, memWriteIn, aluSrc, braSrc;
    logic [exPkg::dataW-1:0] a, b, imm, pcIn;
    logic [4:0]              shamt;
    exPkg::aluFuncE          aluFunc;
    exPkg::mulFuncE          mulFunc;
    exPkg::brCodeE           brCode;
    logic                    brRt;
    logic [exPkg::accW-1:0]  out;
    exPkg::flagsT            flags;
    logic [exPkg::dataW-1:0] pcOut;
    logic                    regWriteOut, memWriteOut, branchTaken;

    // Vector table loaded from the data file
    logic [127:0]            vecName [0:maxVec-1];
    int                      vecGap [0:maxVec-1];       // Bubbles before the vector
    logic [8:0]              vecCtrl [0:maxVec-1];
    logic [31:0]             vecA [0:maxVec-1];
    logic [31:0]             vecB [0:maxVec-1];
    logic [31:0]             vecImm [0:maxVec-1];
    logic [31:0]             vecPc [0:maxVec-1];
    logic [4:0]              vecShamt [0:maxVec-1];
    logic [5:0]              vecAluFunc [0:maxVec-1];
    logic [5:0]              vecMulFunc [0:maxVec-1];
    logic [2:0]              vecBrCode [0:maxVec-1];
    logic                    vecBrRt [0:maxVec-1];
    logic [63:0]             expOut [0:maxVec-1];
    logic [3:0]              expFlags [0:maxVec-1];     // c z o n
    logic [31:0]             expPc [0:maxVec-1];
    logic                    expRw [0:maxVec-1];
    logic                    expBt [0:maxVec-1];
    int                      numVec;

    // Instruction waiting for its registered result
    logic                    pendValid;
    logic                    pendIdle;                  // Bubble, no store allowed
    logic [127:0]            pendName;
    logic [exPkg::accW-1:0]  pendOut;
    exPkg::flagsT            pendFlags;
    logic [exPkg::dataW-1:0] pendPc;
    logic                    pendRw, pendBt;
    logic [exPkg::dataW-1:0] bubblePc;

    int                      cycleLimit;
    logic                    limitReady;

    executeStage u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    //------------------------------------------------------
    // Failure reporting and compare tasks
    //------------------------------------------------------
    task automatic failRun(input string why);
        $display("%s", why);
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic compareResult(input logic [127:0] name,
                                 input logic [exPkg::accW-1:0] expVal,
                                 input logic [exPkg::accW-1:0] actVal);
        if (actVal !== expVal) begin
            failRun($sformatf("mismatch %0s result expected %h actual %h",
                              name, expVal, actVal));
        end
    endtask

    task automatic compareFlags(input logic [127:0] name, input exPkg::flagsT expVal,
                                input exPkg::flagsT actVal);
        if (actVal !== expVal) begin
            failRun($sformatf("mismatch %0s flags expected %b actual %b",
                              name, expVal, actVal));
        end
    endtask

    task automatic compareBranch(input logic [127:0] name,
                                 input logic [exPkg::dataW-1:0] expPcVal,
                                 input logic expTaken,
                                 input logic [exPkg::dataW-1:0] actPcVal,
                                 input logic actTaken);
        if (actPcVal !== expPcVal) begin
            failRun($sformatf("mismatch %0s pcOut expected %h actual %h",
                              name, expPcVal, actPcVal));
        end
        if (actTaken !== expTaken) begin
            failRun($sformatf("mismatch %0s branchTaken expected %b actual %b",
                              name, expTaken, actTaken));
        end
    endtask

    task automatic compareWrite(input logic [127:0] name, input string what,
                                input logic expVal, input logic actVal);
        if (actVal !== expVal) begin
            failRun($sformatf("mismatch %0s %s expected %b actual %b",
                              name, what, expVal, actVal));
        end
    endtask

    //------------------------------------------------------
    // Vector file and stimulus
    //------------------------------------------------------
    task automatic loadVectors();
        int    fd;
        int    code;
        string line;
        numVec = 0;
        fd = $fopen("sim/exInput.txt", "r");
        if (fd == 0) begin
            failRun("could not open the vector file sim/exInput.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                code = $fgets(line, fd);
                if (code > 0 && line.len() > 1 && line[0] != "#") begin
                    code = $sscanf(line,
                        "%s %d %b %h %h %h %h %h %h %h %h %b %h %b %h %b %b",
                        vecName[numVec], vecGap[numVec], vecCtrl[numVec],
                        vecA[numVec], vecB[numVec], vecImm[numVec], vecPc[numVec],
                        vecShamt[numVec], vecAluFunc[numVec], vecMulFunc[numVec],
                        vecBrCode[numVec], vecBrRt[numVec], expOut[numVec],
                        expFlags[numVec], expPc[numVec], expRw[numVec], expBt[numVec]);
                    if (code != 17 || numVec >= maxVec - 1) begin
                        failRun($sformatf("vector %0d could not be read from the file",
                                          numVec + 1));
                    end else begin
                        numVec++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic driveVector(input int idx);
        {aluOp, mulOp, jump, branch, zeroB, regWriteIn, memWriteIn, aluSrc, braSrc}
            <= vecCtrl[idx];
        a       <= vecA[idx];
        b       <= vecB[idx];
        imm     <= vecImm[idx];
        pcIn    <= vecPc[idx];
        shamt   <= vecShamt[idx];
        aluFunc <= exPkg::aluFuncE'(vecAluFunc[idx]);
        mulFunc <= exPkg::mulFuncE'(vecMulFunc[idx]);
        brCode  <= exPkg::brCodeE'(vecBrCode[idx]);
        brRt    <= vecBrRt[idx];
    endtask

    // No op strobe, random operands and qualifiers
    task automatic driveBubble();
        bubblePc = $urandom();
        {aluOp, mulOp, jump, branch} <= 4'b0000;
        {zeroB, regWriteIn, memWriteIn, aluSrc, braSrc} <= 5'($urandom());
        a       <= $urandom();
        b       <= $urandom();
        imm     <= $urandom();
        pcIn    <= bubblePc;
        shamt   <= 5'($urandom());
        brRt    <= 1'($urandom());
        aluFunc <= exPkg::ADD;
        mulFunc <= exPkg::MADD;                 // Accumulator must still hold
        brCode  <= exPkg::BEQ;
    endtask

    // Drives one instruction and checks the one issued a cycle before
    task automatic issueCycle(input int idx);
        @(posedge clk);
        if (idx < 0) begin
            driveBubble();
        end else begin
            driveVector(idx);
        end
        @(negedge clk);
        if (pendValid) begin
            compareResult(pendName, pendOut, out);
            compareFlags(pendName, pendFlags, flags);
            compareBranch(pendName, pendPc, pendBt, pcOut, branchTaken);
            compareWrite(pendName, "regWriteOut", pendRw, regWriteOut);
            if (pendIdle) begin
                compareWrite(pendName, "memWriteOut", 1'b0, memWriteOut);
            end
        end
        if (idx < 0) begin
            pendName  = "bubble";
            pendIdle  = 1'b1;
            pendOut   = '0;
            pendFlags = exPkg::flagsT'(4'b0100);    // Zero result only
            pendPc    = bubblePc;
            pendRw    = 1'b0;
            pendBt    = 1'b0;
        end else begin
            pendName  = vecName[idx];
            pendIdle  = 1'b0;
            pendOut   = expOut[idx];
            pendFlags = exPkg::flagsT'(expFlags[idx]);
            pendPc    = expPc[idx];
            pendRw    = expRw[idx];
            pendBt    = expBt[idx];
        end
        pendValid = 1'b1;
    endtask

    initial begin
        wait (limitReady);
        repeat (cycleLimit) @(posedge clk);
        failRun($sformatf("watchdog expired, run still busy after %0d cycles", cycleLimit));
    end

    //------------------------------------------------------
    // Main sequence
    //------------------------------------------------------
    initial begin
        arstN      = 1'b0;
        {aluOp, mulOp, jump, branch, zeroB} = 5'b00000;
        {regWriteIn, memWriteIn, aluSrc, braSrc} = 4'b0000;
        a          = '0;
        b          = '0;
        imm        = '0;
        pcIn       = '0;
        shamt      = '0;
        aluFunc    = exPkg::ADD;
        mulFunc    = exPkg::MULT;
        brCode     = exPkg::BEQ;
        brRt       = 1'b0;
        pendValid  = 1'b0;
        pendIdle   = 1'b0;
        limitReady = 1'b0;
        void'($urandom(32'h4077_a1b0));

        loadVectors();
        cycleLimit = 10 + 2 + 20;                   // Reset, release and flush
        for (int i = 0; i < numVec; i++) begin
            cycleLimit += vecGap[i] + 1;
        end
        limitReady = 1'b1;

        repeat (10) @(posedge clk);
        @(negedge clk);
        compareResult("reset", '0, out);
        compareFlags("reset", '0, flags);
        compareBranch("reset", '0, 1'b0, pcOut, branchTaken);
        compareWrite("reset", "regWriteOut", 1'b0, regWriteOut);
        compareWrite("reset", "memWriteOut", 1'b0, memWriteOut);
        @(posedge clk);
        arstN <= 1'b1;

        for (int i = 0; i < numVec; i++) begin
            repeat (vecGap[i]) issueCycle(-1);
            issueCycle(i);
        end
        issueCycle(-1);                             // Flushes the last result

        $display("all tests passed");
        $finish;
    end

endmodule
